//--- all.f
rtl/uart_rx_pkg.sv
rtl/axil_pkg.sv
rtl/uart_rx_sampler.sv
rtl/uart_rx_frame.sv
rtl/uart_rx_regs.sv
rtl/uart_rx_top.sv
dv/uart_rx_sva.sv
dv/tb_uart_rx.sv

//--- Makefile
# Verilator build and run of the uart receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_rx
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FILELIST := all.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a listed source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_uart_rx.sv
// --------------------------------------------------
// uart receiver testbench
// drives the AXI4-Lite port and the rx line through
// directed tests and checks data, flags and responses
// --------------------------------------------------
module tb_uart_rx
  import uart_rx_pkg::*;
  import axil_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int TEST_DIV      = 3;                          // 4 clocks per tick
  localparam int BIT_CLKS      = OVERSAMPLE * (TEST_DIV + 1);
  localparam int NUM_FRAMES    = 16;                         // 15 frames plus the glitch gap
  localparam int WATCHDOG_TIME = NUM_FRAMES * 11 * BIT_CLKS * 2 * CLK_PERIOD + 100000;
  localparam int POLL_LIMIT    = 50;

  logic        clk = 1'b0;
  logic        aresetn;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        rx;
  logic        irq;
  logic [15:0] lfsr_q;
  int          errors;
  int          checks;

  uart_rx_top uart_rx_top_i (
    .clk      (clk),
    .aresetn  (aresetn),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .rx       (rx),
    .irq      (irq)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // random data and compare tasks
  // --------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb)
      s = s ^ 16'hb400;   // x^16 + x^14 + x^13 + x^11 + 1
    return s;
  endfunction

  task automatic rand_byte(output rx_data_t b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      b[i]   = lfsr_q[0];
    end
  endtask

  function automatic logic [3:0] status_bits(input logic full, input logic ovf,
                                             input logic par, input logic frm);
    logic [3:0] s;
    s                = '0;
    s[STAT_FULL]     = full;
    s[STAT_OVERFLOW] = ovf;
    s[STAT_PARITY]   = par;
    s[STAT_FRAMING]  = frm;
    return s;
  endfunction

  task automatic check_data(input string what, input rx_data_t got, input rx_data_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %0t: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input string what, input logic [3:0] got,
                              input logic [3:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %0t: %s got %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %0t: %s response %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string what, input axil_data_t got, input axil_data_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %0t: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // bus and line drivers
  // --------------------------------------------------
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output logic [1:0] resp);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    @(negedge clk);
    while (!(axil_rsp.awready && axil_rsp.wready))
      @(negedge clk);
    @(negedge clk);                  // accepted on the edge before
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    while (!axil_rsp.bvalid)
      @(negedge clk);
    resp = axil_rsp.bresp;
    @(negedge clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output logic [1:0] resp);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready)
      @(negedge clk);
    @(negedge clk);
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    while (!axil_rsp.rvalid)
      @(negedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge clk);
    axil_req.rready = 1'b0;
  endtask

  task automatic write_ok(input axil_addr_t addr, input axil_data_t data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_resp("write", resp, RESP_OKAY);
  endtask

  task automatic read_ok(input axil_addr_t addr, output axil_data_t data);
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_resp("read", resp, RESP_OKAY);
  endtask

  task automatic drive_bit(input logic v);
    rx = v;
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  // start, data lsb first, optional parity, stop, one idle bit
  task automatic send_frame(input rx_data_t data, input frame_cfg_t fmt,
                            input logic bad_par, input logic stop_bit);
    logic par;
    par = fmt.odd;                   // odd parity counts from one
    drive_bit(1'b0);
    for (int i = 0; i < (fmt.bit8 ? 8 : 7); i++)
    begin
      drive_bit(data[i]);
      par = par ^ data[i];
    end
    if (fmt.parity_en)
      drive_bit(par ^ bad_par);
    drive_bit(stop_bit);
    drive_bit(1'b1);
  endtask

  task automatic wait_status(input int bit_pos, input string what);
    axil_data_t w;
    int         n;
    n = 0;
    read_ok(REG_STATUS, w);
    while (!w[bit_pos] && n < POLL_LIMIT)
    begin
      n++;
      read_ok(REG_STATUS, w);
    end
    if (!w[bit_pos])
    begin
      $display("ERROR at %0t: %s flag never came up in STATUS", $time, what);
      errors++;
    end
  endtask

  task automatic expect_status(input string what, input logic [3:0] exp);
    axil_data_t w;
    read_ok(REG_STATUS, w);
    check_status(what, w[3:0], exp);
  endtask

  task automatic expect_data(input string what, input rx_data_t exp);
    axil_data_t w;
    read_ok(REG_DATA, w);
    check_data(what, w[7:0], exp);
  endtask

  task automatic finish_test(input string name, input int err0);
    $display("test %-10s done, %0d errors", name, errors - err0);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_regs();
    axil_data_t w;
    logic [1:0] resp;
    int         err0;
    err0 = errors;
    read_ok(REG_CTRL, w);
    check_word("CTRL reset", w, 32'h4);          // 8 data bits, no parity
    read_ok(REG_DIV, w);
    check_word("DIV reset", w, {16'h0, DIV_RESET});
    expect_status("STATUS reset", 4'b0000);
    check_word("irq reset", {31'b0, irq}, 32'h0);
    write_ok(REG_CTRL, 32'h3);
    read_ok(REG_CTRL, w);
    check_word("CTRL readback", w, 32'h3);
    write_ok(REG_DIV, TEST_DIV);
    read_ok(REG_DIV, w);
    check_word("DIV readback", w, TEST_DIV);
    axil_read(4'h2, w, resp);
    check_resp("unmapped read", resp, RESP_SLVERR);
    axil_write(4'h6, 32'h1, resp);
    check_resp("unmapped write", resp, RESP_SLVERR);
    axil_write(REG_DATA, 32'h55, resp);
    check_resp("DATA write", resp, RESP_SLVERR);
    finish_test("regs", err0);
  endtask

  task automatic test_8bit();
    frame_cfg_t fmt;
    rx_data_t   b;
    int         err0;
    err0 = errors;
    fmt  = '{bit8: 1'b1, parity_en: 1'b0, odd: 1'b0};
    write_ok(REG_CTRL, {29'b0, fmt});
    for (int i = 0; i < 8; i++)
    begin
      rand_byte(b);
      send_frame(b, fmt, 1'b0, 1'b1);
      wait_status(STAT_FULL, "full");
      expect_status("8-bit status", status_bits(1'b1, 1'b0, 1'b0, 1'b0));
      check_word("irq on full", {31'b0, irq}, 32'h1);
      expect_data("8-bit data", b);
      expect_status("8-bit after read", 4'b0000);
    end
    finish_test("8bit", err0);
  endtask

  task automatic test_parity();
    frame_cfg_t fmt;
    rx_data_t   b;
    int         err0;
    err0 = errors;
    for (int odd = 0; odd < 2; odd++)
    begin
      fmt = '{bit8: 1'b0, parity_en: 1'b1, odd: odd[0]};
      write_ok(REG_CTRL, {29'b0, fmt});
      rand_byte(b);
      send_frame(b, fmt, 1'b0, 1'b1);
      wait_status(STAT_FULL, "full");
      expect_status("parity ok status", status_bits(1'b1, 1'b0, 1'b0, 1'b0));
      expect_data("7-bit data", {1'b0, b[6:0]});
    end
    // odd format still set, bad parity bit
    rand_byte(b);
    send_frame(b, fmt, 1'b1, 1'b1);
    wait_status(STAT_FULL, "full");
    expect_status("parity error status", status_bits(1'b1, 1'b0, 1'b1, 1'b0));
    expect_data("bad parity data", {1'b0, b[6:0]});
    write_ok(REG_STATUS, 32'h1 << STAT_PARITY);
    expect_status("parity cleared", 4'b0000);
    finish_test("parity", err0);
  endtask

  task automatic test_framing();
    frame_cfg_t fmt;
    rx_data_t   b;
    int         err0;
    err0 = errors;
    fmt  = '{bit8: 1'b1, parity_en: 1'b0, odd: 1'b0};
    write_ok(REG_CTRL, {29'b0, fmt});
    rand_byte(b);
    send_frame(b, fmt, 1'b0, 1'b0);
    wait_status(STAT_FULL, "full");
    expect_status("framing status", status_bits(1'b1, 1'b0, 1'b0, 1'b1));
    expect_data("framing data", b);
    write_ok(REG_STATUS, 32'h1 << STAT_FRAMING);
    expect_status("framing cleared", 4'b0000);
    finish_test("framing", err0);
  endtask

  task automatic test_overflow();
    frame_cfg_t fmt;
    rx_data_t   b1;
    rx_data_t   b2;
    int         err0;
    err0 = errors;
    fmt  = '{bit8: 1'b1, parity_en: 1'b0, odd: 1'b0};
    write_ok(REG_CTRL, {29'b0, fmt});
    rand_byte(b1);
    rand_byte(b2);
    send_frame(b1, fmt, 1'b0, 1'b1);
    wait_status(STAT_FULL, "full");
    send_frame(b2, fmt, 1'b0, 1'b1);
    wait_status(STAT_OVERFLOW, "overflow");
    expect_status("overflow status", status_bits(1'b1, 1'b1, 1'b0, 1'b0));
    expect_data("first byte kept", b1);
    expect_status("overflow cleared by read", 4'b0000);
    finish_test("overflow", err0);
  endtask

  task automatic test_glitch();
    frame_cfg_t fmt;
    rx_data_t   b;
    int         err0;
    err0 = errors;
    fmt  = '{bit8: 1'b1, parity_en: 1'b0, odd: 1'b0};
    rx = 1'b0;                       // one clock low on an idle line
    @(negedge clk);
    rx = 1'b1;
    repeat (3 * BIT_CLKS) @(negedge clk);
    expect_status("no frame from glitch", 4'b0000);
    rand_byte(b);
    send_frame(b, fmt, 1'b0, 1'b1);
    wait_status(STAT_FULL, "full");
    expect_data("data after glitch", b);
    expect_status("glitch test end", 4'b0000);
    finish_test("glitch", err0);
  endtask

  initial
  begin
    axil_req = '0;
    rx       = 1'b1;
    aresetn  = 1'b0;
    lfsr_q   = 16'd11347;
    errors   = 0;
    checks   = 0;
    repeat (4) @(negedge clk);
    aresetn = 1'b1;
    @(negedge clk);
    test_regs();
    test_8bit();
    test_parity();
    test_framing();
    test_overflow();
    test_glitch();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog, sized from the frame count
  initial
  begin
    #(WATCHDOG_TIME);
    $display("timeout: the tests were still running at %0t", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- dv/uart_rx_sva.sv
// --------------------------------------------------
// AXI4-Lite handshake assertions
// bound into the uart rx register block
// --------------------------------------------------
module uart_rx_sva
  import axil_pkg::*;
(
  input logic      clk,
  input logic      aresetn,
  input axil_req_t axil_req,
  input axil_rsp_t axil_rsp
);

  // write response stays until the master takes it
  bvalid_hold: assert property (@(posedge clk) disable iff (!aresetn)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk) disable iff (!aresetn)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else $error("rvalid dropped before rready");

  rdata_stable: assert property (@(posedge clk) disable iff (!aresetn)
    axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rdata))
    else $error("rdata changed while rvalid waited");

  // address and data are only taken together
  awready_both: assert property (@(posedge clk) disable iff (!aresetn)
    axil_rsp.awready |-> axil_req.awvalid && axil_req.wvalid)
    else $error("awready without both awvalid and wvalid");

endmodule

bind uart_rx_regs uart_rx_sva uart_rx_sva_i (
  .clk      (clk),
  .aresetn  (aresetn),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp)
);

//--- rtl/uart_rx_top.sv
// --------------------------------------------------
// uart receiver top
// sampler, frame engine and AXI4-Lite registers
// --------------------------------------------------
module uart_rx_top
  import uart_rx_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      aresetn,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  input  logic      rx,
  output logic      irq
);

  baud_div_t  baud_div;
  frame_cfg_t cfg;
  rx_frame_t  frame;
  logic       frame_valid;
  logic       tick;
  logic       rx_filt;

  uart_rx_sampler uart_rx_sampler_i (
    .clk      (clk),
    .aresetn  (aresetn),
    .rx       (rx),
    .baud_div (baud_div),
    .tick     (tick),
    .rx_filt  (rx_filt)
  );

  uart_rx_frame uart_rx_frame_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .tick        (tick),
    .rx_filt     (rx_filt),
    .cfg         (cfg),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  uart_rx_regs uart_rx_regs_i (
    .clk         (clk),
    .aresetn     (aresetn),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .frame       (frame),
    .frame_valid (frame_valid),
    .cfg         (cfg),
    .baud_div    (baud_div),
    .irq         (irq)
  );

endmodule

//--- rtl/uart_rx_regs.sv
// --------------------------------------------------
// uart rx register block
// AXI4-Lite slave with CTRL, DIV, STATUS and DATA,
// sticky receive flags and the interrupt level
// --------------------------------------------------
module uart_rx_regs
  import uart_rx_pkg::*;
  import axil_pkg::*;
(
  input  logic       clk,
  input  logic       aresetn,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  input  rx_frame_t  frame,
  input  logic       frame_valid,
  output frame_cfg_t cfg,
  output baud_div_t  baud_div,
  output logic       irq
);

  logic       awready_q;
  logic       bvalid_q;
  logic [1:0] bresp_q;
  logic       arready_q;
  logic       rvalid_q;
  logic [1:0] rresp_q;
  axil_data_t rdata_q;

  rx_data_t   data_q;
  logic       full_q;
  logic       ovf_q;
  logic       par_q;
  logic       frm_q;
  logic [3:0] status;

  logic       wr_en;
  logic       rd_en;
  logic       wr_hit;
  logic       rd_data;
  logic       full_eff;
  axil_data_t rd_word;
  logic       rd_hit;

  // --------------------------------------------------
  // bus handshakes
  // --------------------------------------------------
  assign wr_en   = awready_q & axil_req.awvalid & axil_req.wvalid;
  assign rd_en   = arready_q & axil_req.arvalid;
  assign wr_hit  = (axil_req.awaddr == REG_CTRL) || (axil_req.awaddr == REG_DIV) ||
                   (axil_req.awaddr == REG_STATUS);
  assign rd_data = rd_en && (axil_req.araddr == REG_DATA);

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= RESP_OKAY;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rresp_q   <= RESP_OKAY;
    end
    else
    begin
      // one cycle ready pulse, only with no response pending
      awready_q <= axil_req.awvalid & axil_req.wvalid & ~awready_q & ~bvalid_q;
      arready_q <= axil_req.arvalid & ~arready_q & ~rvalid_q;

      if (wr_en)
      begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end
      else if (axil_req.bready)
        bvalid_q <= 1'b0;

      if (rd_en)
      begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end
      else if (axil_req.rready)
        rvalid_q <= 1'b0;
    end
  end

  // read mux
  always_comb
  begin
    rd_word = '0;
    rd_hit  = 1'b1;
    case (axil_req.araddr)
      REG_CTRL:   rd_word[2:0]  = cfg;
      REG_DIV:    rd_word[15:0] = baud_div;
      REG_STATUS: rd_word[3:0]  = status;
      REG_DATA:   rd_word[7:0]  = data_q;
      default:    rd_hit        = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
      rdata_q <= rd_word;   // held until rready
  end

  // --------------------------------------------------
  // control registers and flags
  // --------------------------------------------------
  assign full_eff = full_q & ~rd_data;   // a read in the same cycle frees the buffer

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      cfg      <= '{bit8: 1'b1, parity_en: 1'b0, odd: 1'b0};
      baud_div <= DIV_RESET;
      full_q   <= 1'b0;
      ovf_q    <= 1'b0;
      par_q    <= 1'b0;
      frm_q    <= 1'b0;
    end
    else
    begin
      if (wr_en && (axil_req.awaddr == REG_CTRL))
        cfg <= frame_cfg_t'(axil_req.wdata[2:0]);
      if (wr_en && (axil_req.awaddr == REG_DIV))
        baud_div <= axil_req.wdata[15:0];

      if (rd_data)
      begin
        full_q <= 1'b0;
        ovf_q  <= 1'b0;
      end
      if (wr_en && (axil_req.awaddr == REG_STATUS))
      begin
        // write one to clear, full is read only
        if (axil_req.wdata[STAT_OVERFLOW]) ovf_q <= 1'b0;
        if (axil_req.wdata[STAT_PARITY])   par_q <= 1'b0;
        if (axil_req.wdata[STAT_FRAMING])  frm_q <= 1'b0;
      end

      // a new frame beats any clear in the same cycle
      if (frame_valid)
      begin
        full_q <= 1'b1;
        if (full_eff)
          ovf_q <= 1'b1;
        if (frame.parity_err)
          par_q <= 1'b1;
        if (frame.framing_err)
          frm_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (frame_valid && !full_eff)
      data_q <= frame.data;   // old byte stays on overflow
  end

  always_comb
  begin
    status                = '0;
    status[STAT_FULL]     = full_q;
    status[STAT_OVERFLOW] = ovf_q;
    status[STAT_PARITY]   = par_q;
    status[STAT_FRAMING]  = frm_q;
  end

  assign irq = |status;

  always_comb
  begin
    axil_rsp         = '0;
    axil_rsp.awready = awready_q;
    axil_rsp.wready  = awready_q;   // address and data taken together
    axil_rsp.bresp   = bresp_q;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = arready_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
    axil_rsp.rvalid  = rvalid_q;
  end

endmodule

//--- rtl/uart_rx_frame.sv
// --------------------------------------------------
// uart rx frame engine
// start confirmation, bit timing, data shift,
// parity check and stop bit check
// --------------------------------------------------
module uart_rx_frame
  import uart_rx_pkg::*;
(
  input  logic       clk,
  input  logic       aresetn,
  input  logic       tick,
  input  logic       rx_filt,
  input  frame_cfg_t cfg,
  output rx_frame_t  frame,
  output logic       frame_valid
);

  rx_state_e  state;
  logic [3:0] tick_cnt;    // ticks within the current bit
  logic [3:0] bit_idx;     // data and parity bits taken so far
  frame_cfg_t cfg_q;       // format of the frame in flight
  rx_data_t   shreg;
  logic       par_acc;     // running xor of the data bits
  logic       par_err;

  logic [3:0] n_data;
  logic [3:0] last_bit;
  logic       start_ok;
  logic       bit_smp;
  logic       stop_smp;
  logic       is_data;

  // --------------------------------------------------
  // strobes
  // --------------------------------------------------
  assign n_data   = cfg_q.bit8 ? 4'd8 : 4'd7;
  assign last_bit = n_data - 4'd1 + {3'b000, cfg_q.parity_en};
  assign is_data  = (bit_idx < n_data);

  assign start_ok = tick && (state == st_idle) && !rx_filt &&
                    (tick_cnt == 4'(START_TICKS - 1));
  assign bit_smp  = tick && (state == st_data) && (tick_cnt == 4'(OVERSAMPLE - 1));
  assign stop_smp = tick && (state == st_stop) && (tick_cnt == 4'(OVERSAMPLE - 1));

  // --------------------------------------------------
  // state machine and bit timing
  // --------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state       <= st_idle;
      tick_cnt    <= '0;
      bit_idx     <= '0;
      cfg_q       <= '{bit8: 1'b1, parity_en: 1'b0, odd: 1'b0};
      par_acc     <= 1'b0;
      par_err     <= 1'b0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      if (tick)
      begin
        case (state)
          st_idle:
          begin
            if (rx_filt)
              tick_cnt <= '0;        // line back high, restart the count
            else if (start_ok)
            begin
              state    <= st_data;   // mid start bit reached
              tick_cnt <= '0;
              bit_idx  <= '0;
              cfg_q    <= cfg;
              par_acc  <= 1'b0;
              par_err  <= 1'b0;
            end
            else
              tick_cnt <= tick_cnt + 1'b1;
          end
          st_data:
          begin
            tick_cnt <= tick_cnt + 1'b1;   // wraps to 0 on the sample
            if (bit_smp)
            begin
              bit_idx <= bit_idx + 1'b1;
              if (is_data)
                par_acc <= par_acc ^ rx_filt;
              else
                par_err <= par_acc ^ rx_filt ^ cfg_q.odd;
              if (bit_idx == last_bit)
                state <= st_stop;
            end
          end
          st_stop:
          begin
            tick_cnt <= tick_cnt + 1'b1;
            if (stop_smp)
            begin
              state       <= st_wait;
              tick_cnt    <= '0;
              frame_valid <= 1'b1;
            end
          end
          st_wait:
          begin
            // a low stop bit may leave the line low for a while
            if (rx_filt || (tick_cnt == 4'(WAIT_TICKS - 1)))
            begin
              state    <= st_idle;
              tick_cnt <= '0;
            end
            else
              tick_cnt <= tick_cnt + 1'b1;
          end
          default:
          begin
            state    <= st_idle;
            tick_cnt <= '0;
          end
        endcase
      end
    end
  end

  // --------------------------------------------------
  // data path
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (start_ok)
      shreg <= '0;                              // keeps bit 7 zero in 7-bit mode
    else if (bit_smp && is_data)
    begin
      if (cfg_q.bit8)
        shreg <= {rx_filt, shreg[7:1]};         // lsb first
      else
        shreg <= {1'b0, rx_filt, shreg[6:1]};
    end

    if (stop_smp)
    begin
      frame.data        <= shreg;
      frame.parity_err  <= par_err;
      frame.framing_err <= !rx_filt;            // stop bit must be high
    end
  end

endmodule

//--- rtl/uart_rx_sampler.sv
// --------------------------------------------------
// uart rx sampler
// programmable oversampling tick and a three-sample
// majority filter on the rx line
// --------------------------------------------------
module uart_rx_sampler
  import uart_rx_pkg::*;
(
  input  logic      clk,
  input  logic      aresetn,
  input  logic      rx,
  input  baud_div_t baud_div,
  output logic      tick,
  output logic      rx_filt
);

  baud_div_t  div_cnt;
  logic       rx_meta;
  logic       rx_sync;
  logic [2:0] hist;     // last three tick samples, newest in bit 2

  // tick divider, period is baud_div + 1 clocks
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else
    begin
      tick <= (div_cnt == '0);
      if (div_cnt == '0)
        div_cnt <= baud_div;   // reload, new divisor takes effect here
      else
        div_cnt <= div_cnt - 1'b1;
    end
  end

  // two-flop synchronizer, idle line is high
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      hist    <= 3'b111;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (tick)
        hist <= {rx_sync, hist[2:1]};
    end
  end

  // any two of three wins, single bad sample is dropped
  assign rx_filt = (hist[0] & hist[1]) | (hist[1] & hist[2]) | (hist[0] & hist[2]);

endmodule

//--- rtl/axil_pkg.sv
// --------------------------------------------------
// AXI4-Lite channel bundles for the register port
// --------------------------------------------------
package axil_pkg;

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // everything the master drives
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // everything the slave drives
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
  } axil_rsp_t;

endpackage

//--- rtl/uart_rx_pkg.sv
// --------------------------------------------------
// uart receiver definitions
// frame format, result type, state encoding,
// bit timing constants and register map
// --------------------------------------------------
package uart_rx_pkg;

  typedef logic [7:0]  rx_data_t;   // one received character
  typedef logic [15:0] baud_div_t;  // clocks per tick, minus one

  // frame format, msb first as in CTRL[2:0]
  typedef struct packed {
    logic bit8;       // 1 = 8 data bits, 0 = 7
    logic parity_en;
    logic odd;        // 1 = odd parity, 0 = even
  } frame_cfg_t;

  typedef struct packed {
    rx_data_t data;
    logic     parity_err;
    logic     framing_err;
  } rx_frame_t;

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_stop,
    st_wait
  } rx_state_e;

  localparam int unsigned OVERSAMPLE  = 16; // ticks per bit
  localparam int unsigned START_TICKS = 8;  // low ticks that confirm a start bit
  localparam int unsigned WAIT_TICKS  = 6;  // max wait for line high after stop
  localparam baud_div_t   DIV_RESET   = 16'd15;

  // register byte offsets
  localparam logic [3:0] REG_CTRL   = 4'h0;
  localparam logic [3:0] REG_DIV    = 4'h4;
  localparam logic [3:0] REG_STATUS = 4'h8;
  localparam logic [3:0] REG_DATA   = 4'hc;

  // status bit positions
  localparam int unsigned STAT_FULL     = 0;
  localparam int unsigned STAT_OVERFLOW = 1;
  localparam int unsigned STAT_PARITY   = 2;
  localparam int unsigned STAT_FRAMING  = 3;

endpackage
